/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := neighbor_fetch_tb
FILELIST  := neighbor_fetch_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ok"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* neighbor_bank_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_bank_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  neighbor_pkg::nbr_req_t              head_req,
    input  logic [neighbor_pkg::nbr_word_w-1:0] rd_data,
    output logic                                take,
    output neighbor_pkg::sram_rd_t              sram_rd,
    output neighbor_pkg::edge_beat_t            beat_out,
    output logic                                busy
);
    import neighbor_pkg::*;

    typedef enum logic {
        st_idle,
        st_stream
    } state_t;

    state_t state, nx_state;
    logic [degree_w:0]     cnt, nx_cnt;   // neighbors covered up to the current word
    logic [degree_w-1:0]   degree_q;
    logic [pe_tag_w-1:0]   tag_q;
    logic [nbr_addr_w-1:0] addr_q, nx_addr;
    logic                  last;
    logic [nbr_id_w-1:0]   upper_id;
    edge_beat_t            nx_beat;

    assign last = ({1'b0, degree_q} <= cnt);
    assign take = (state == st_idle) && head_req.valid;
    assign busy = (state == st_stream) && !last;

    always_comb begin
        nx_state    = state;
        nx_cnt      = cnt;
        nx_addr     = addr_q;
        sram_rd.cen = 1'b1;
        sram_rd.wen = 1'b1;
        sram_rd.a   = addr_q;
        nx_beat     = '0;
        upper_id    = rd_data[nbr_word_w-1:nbr_id_w];
        case (state)
            st_idle: begin
                if (take) begin
                    // word 0 read goes out in the take cycle
                    nx_state    = st_stream;
                    nx_cnt      = (degree_w + 1)'(2);
                    nx_addr     = head_req.start_addr;
                    sram_rd.cen = 1'b0;
                    sram_rd.a   = head_req.start_addr;
                end
            end
            st_stream: begin
                if (last && degree_q[0]) begin
                    upper_id = '0; // odd degree, last word has one id
                end
                nx_beat.valid  = 1'b1;
                nx_beat.sos    = (cnt == (degree_w + 1)'(2));
                nx_beat.eos    = last;
                nx_beat.pe_tag = tag_q;
                nx_beat.degree = degree_q;
                nx_beat.data   = {upper_id, rd_data[nbr_id_w-1:0]};
                if (last) begin
                    nx_state = st_idle;
                    nx_cnt   = '0;
                end else begin
                    nx_cnt      = cnt + (degree_w + 1)'(2);
                    nx_addr     = addr_q + 1'b1;
                    sram_rd.cen = 1'b0;
                    sram_rd.a   = addr_q + 1'b1;
                end
            end
            default: nx_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= st_idle;
            cnt      <= '0;
            beat_out <= '0;
        end else begin
            state    <= nx_state;
            cnt      <= nx_cnt;
            beat_out <= nx_beat; // word from sram registered as a beat
        end
    end

    // request fields held for the whole stream
    always_ff @(posedge clk) begin
        addr_q <= nx_addr;
        if (take) begin
            degree_q <= head_req.degree;
            tag_q    <= head_req.pe_tag;
        end
    end

endmodule

`default_nettype wire

/* neighbor_fetch_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_fetch_chk (
    input logic                     clk,
    input logic                     reset,
    input logic                     take,
    input logic                     busy,
    input neighbor_pkg::edge_beat_t beat_out
);
    int   fail_count = 0;
    logic open_list;  // sos seen, eos still to come
    logic sos_beat;

    assign sos_beat = beat_out.valid && beat_out.sos;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            open_list <= 1'b0;
        end else if (beat_out.valid) begin
            open_list <= !beat_out.eos;
        end
    end

    // busy only in a stream cycle whose beat is not the last one
    idle_not_busy: assert property (@(posedge clk) disable iff (!reset)
        busy |=> beat_out.valid && !beat_out.eos)
        else begin
            $error("busy high outside a stream cycle that has more beats to come");
            fail_count++;
        end

    take_then_sos: assert property (@(posedge clk) disable iff (!reset)
        take |-> ##2 sos_beat)
        else begin
            $error("take not followed by a sos beat two cycles later");
            fail_count++;
        end

    // a list runs without gaps to its eos, and no new sos starts inside it
    no_sos_in_list: assert property (@(posedge clk) disable iff (!reset)
        sos_beat |-> !open_list)
        else begin
            $error("sos beat before the eos of the previous list");
            fail_count++;
        end

    list_reaches_eos: assert property (@(posedge clk) disable iff (!reset)
        open_list |-> beat_out.valid)
        else begin
            $error("stream stopped before its eos beat");
            fail_count++;
        end

endmodule

bind neighbor_bank_ctrl neighbor_fetch_chk i_bank_ctrl_chk (
    .clk     (clk),
    .reset   (reset),
    .take    (take),
    .busy    (busy),
    .beat_out(beat_out)
);

`default_nettype wire

/* neighbor_fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_fetch_tb;
    import neighbor_pkg::*;

    localparam int num_vertices = 16;
    localparam int fifo_depth   = 4;
    localparam int num_reqs     = 21;

    typedef edge_beat_t beat_list_t[$];

    logic                   clk = 1'b0;
    logic                   reset;
    vertex_req_t            vertex_req;
    logic                   tbl_we;
    logic [vertex_id_w-1:0] tbl_addr;
    vertex_info_t           tbl_data;
    logic                   mem_we;
    logic [nbr_addr_w-1:0]  mem_addr;
    logic [nbr_word_w-1:0]  mem_wdata;
    edge_beat_t             beat_out;
    logic                   busy;
    logic                   overflow;

    logic [nbr_word_w-1:0] mem_copy [1 << nbr_addr_w];
    vertex_info_t          tbl_copy [num_vertices];
    int                    deg_of [num_vertices];
    int                    seq_vid [num_reqs];  // vertex of each request in issue order
    edge_beat_t            exp_q [$];
    logic                  busy_q = 1'b0;       // busy seen at the previous falling edge
    int errors       = 0;
    int beats_seen   = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycles       = 0;
    int limit        = 0;
    bit running      = 1'b0;

    neighbor_fetch_top #(
        .num_vertices(num_vertices),
        .fifo_depth  (fifo_depth)
    ) i_neighbor_fetch_top (.*);

    always #5 clk = ~clk;

    // expected stream of one request, built from the sram copy
    function automatic beat_list_t expected_beats(logic [nbr_addr_w-1:0] start,
                                                  logic [degree_w-1:0] degree,
                                                  logic [pe_tag_w-1:0] tag);
        beat_list_t            beats;
        edge_beat_t            b;
        int                    words;
        logic [nbr_addr_w-1:0] addr;
        words = (int'(degree) + 1) / 2;
        for (int k = 0; k < words; k++) begin
            addr     = start + nbr_addr_w'(k);  // wraps like the bank address
            b        = '0;
            b.valid  = 1'b1;
            b.sos    = (k == 0);
            b.eos    = (k == words - 1);
            b.pe_tag = tag;
            b.degree = degree;
            b.data   = mem_copy[addr];
            if (b.eos && degree[0]) begin
                b.data[nbr_word_w-1:nbr_id_w] = '0;
            end
            beats.push_back(b);
        end
        return beats;
    endfunction

    function automatic int cycle_limit();
        int sum;
        sum = 0;
        foreach (seq_vid[i]) sum += (deg_of[seq_vid[i]] + 1) / 2 + 3;
        return 2 * sum + 200;
    endfunction

    task automatic check_field(string name, int got, int want);
        assert (got == want)
            else begin
                $display("ERROR %0t %s: got %0h, expected %0h", $time, name, got, want);
                errors++;
            end
    endtask

    task automatic load_memories();
        for (int a = 0; a < (1 << nbr_addr_w); a++) begin
            @(negedge clk);
            mem_we      = 1'b1;
            mem_addr    = nbr_addr_w'(a);
            mem_wdata   = nbr_word_w'($urandom);
            mem_copy[a] = mem_wdata;
            tbl_we      = (a < num_vertices);  // table loads alongside the first words
            if (a < num_vertices) begin
                tbl_addr            = vertex_id_w'(a);
                tbl_data.start_addr = nbr_addr_w'($urandom);
                tbl_data.degree     = degree_w'(deg_of[a]);
                tbl_copy[a]         = tbl_data;
            end
        end
        @(negedge clk);
        mem_we = 1'b0;
        tbl_we = 1'b0;
    endtask

    task automatic send_request(int idx, bit expected, int gap);
        vertex_info_t        info;
        logic [pe_tag_w-1:0] tag;
        beat_list_t          beats;
        info = tbl_copy[seq_vid[idx]];
        tag  = pe_tag_w'(idx + 1);
        if (expected) begin
            beats = expected_beats(info.start_addr, info.degree, tag);
            foreach (beats[k]) exp_q.push_back(beats[k]);
        end
        @(negedge clk);
        vertex_req.valid     = 1'b1;
        vertex_req.vertex_id = vertex_id_w'(seq_vid[idx]);
        vertex_req.pe_tag    = tag;
        repeat (gap) begin
            @(negedge clk);
            vertex_req = '0;
        end
    endtask

    // only the first `accepted` requests of the run reach the bank
    task automatic run_test(string name, int first, int count, int accepted, int gap,
                            int exp_ovf);
        int errors_before;
        int beats_before;
        errors_before = errors;
        beats_before  = beats_seen;
        for (int i = first; i < first + count; i++) begin
            send_request(i, (i - first) < accepted, gap);
        end
        @(negedge clk);
        vertex_req = '0;
        while (exp_q.size() != 0 || busy) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // room for a stray beat
        check_field("overflow", int'(overflow), exp_ovf);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok, %0d beats", tests_run, name, beats_seen - beats_before);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    always @(negedge clk) begin
        edge_beat_t want;
        logic       exp_busy;
        exp_busy = 1'b0;
        if (reset && beat_out.valid) begin
            beats_seen++;
            assert (exp_q.size() != 0)
                else begin
                    $display("%0t: beat arrived with no request outstanding", $time);
                    errors++;
                end
            if (exp_q.size() != 0) begin
                want     = exp_q.pop_front();
                exp_busy = !want.eos;  // cycle before a non-final beat is busy
                check_field("beat_out.sos", int'(beat_out.sos), int'(want.sos));
                check_field("beat_out.eos", int'(beat_out.eos), int'(want.eos));
                check_field("beat_out.pe_tag", int'(beat_out.pe_tag), int'(want.pe_tag));
                check_field("beat_out.degree", int'(beat_out.degree), int'(want.degree));
                check_field("beat_out.data", int'(beat_out.data), int'(want.data));
            end
        end
        if (reset) begin
            check_field("busy", int'(busy_q), int'(exp_busy));
        end
        busy_q = busy;
    end

    always @(posedge clk) begin
        if (running) begin
            cycles++;
            if (cycles > limit) begin
                $display("run stopped after %0d cycles with beats still missing", cycles);
                $display("Test failures found");
                $finish;
            end
        end
    end

    initial begin
        int chk_fails;
        vertex_req = '0;
        tbl_we     = 1'b0;
        tbl_addr   = '0;
        tbl_data   = '0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        reset      = 1'b0;
        deg_of     = '{8, 7, 1, 2, 0, 3, 4, 5, 6, 21, 24, 30, 33, 40, 63, 25};
        seq_vid    = '{0, 1, 2, 3, 5, 6, 7, 8, 3, 4, 5, 9, 10, 11, 12, 13, 14, 15, 9, 10, 11};
        void'($urandom(32'h44d6d46a));
        repeat (8) @(negedge clk);
        reset = 1'b1;
        load_memories();
        limit   = cycle_limit();
        running = 1'b1;
        run_test("even degree", 0, 1, 1, 2, 0);
        run_test("odd degree", 1, 1, 1, 2, 0);
        run_test("single word lists", 2, 2, 2, 2, 0);
        run_test("back to back", 4, 5, 5, 0, 0);
        run_test("empty list dropped", 9, 2, 2, 2, 0);
        run_test("queue overrun", 11, 10, fifo_depth + 1, 0, 1);
        chk_fails = i_neighbor_fetch_top.i_neighbor_bank_ctrl.i_bank_ctrl_chk.fail_count;
        if (chk_fails != 0) begin
            $display("bound controller assertions failed %0d times", chk_fails);
        end
        $display("tests %0d, failed %0d, errors %0d, beats checked %0d",
                 tests_run, tests_failed, errors, beats_seen);
        if (errors == 0 && tests_failed == 0 && chk_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* neighbor_fetch_top.f */
neighbor_pkg.sv
vertex_info_lookup.sv
neighbor_req_fifo.sv
neighbor_bank_ctrl.sv
neighbor_sram.sv
neighbor_fetch_top.sv
neighbor_fetch_chk.sv
neighbor_fetch_tb.sv

/* neighbor_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_fetch_top #(
    parameter int num_vertices = 16,
    parameter int fifo_depth   = 4
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  neighbor_pkg::vertex_req_t            vertex_req,
    input  logic                                 tbl_we,
    input  logic [neighbor_pkg::vertex_id_w-1:0] tbl_addr,
    input  neighbor_pkg::vertex_info_t           tbl_data,
    input  logic                                 mem_we,
    input  logic [neighbor_pkg::nbr_addr_w-1:0]  mem_addr,
    input  logic [neighbor_pkg::nbr_word_w-1:0]  mem_wdata,
    output neighbor_pkg::edge_beat_t             beat_out,
    output logic                                 busy,
    output logic                                 overflow
);
    import neighbor_pkg::*;

    nbr_req_t              lookup_req;
    nbr_req_t              head_req;
    logic                  take;
    sram_rd_t              sram_rd;
    logic [nbr_word_w-1:0] rd_data;

    vertex_info_lookup #(
        .num_vertices(num_vertices)
    ) i_vertex_info_lookup (
        .clk       (clk),
        .reset     (reset),
        .vertex_req(vertex_req),
        .tbl_we    (tbl_we),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .lookup_req(lookup_req)
    );

    neighbor_req_fifo #(
        .fifo_depth(fifo_depth)
    ) i_neighbor_req_fifo (
        .clk     (clk),
        .reset   (reset),
        .push_req(lookup_req),
        .take    (take),
        .head_req(head_req),
        .overflow(overflow)
    );

    neighbor_bank_ctrl i_neighbor_bank_ctrl (
        .clk     (clk),
        .reset   (reset),
        .head_req(head_req),
        .rd_data (rd_data),
        .take    (take),
        .sram_rd (sram_rd),
        .beat_out(beat_out),
        .busy    (busy)
    );

    neighbor_sram i_neighbor_sram (
        .clk      (clk),
        .mem_we   (mem_we),
        .mem_addr (mem_addr),
        .mem_wdata(mem_wdata),
        .sram_rd  (sram_rd),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* neighbor_pkg.sv */
`default_nettype none

package neighbor_pkg;

    parameter int nbr_id_w    = 7;
    parameter int nbr_word_w  = 2 * nbr_id_w;   // two ids per sram word
    parameter int nbr_addr_w  = 8;
    parameter int degree_w    = 6;              // up to 63 neighbors
    parameter int pe_tag_w    = 2;
    parameter int vertex_id_w = 4;

    // external vertex request, one-cycle strobe
    typedef struct packed {
        logic                   valid;
        logic [vertex_id_w-1:0] vertex_id;
        logic [pe_tag_w-1:0]    pe_tag;
    } vertex_req_t;

    // one lookup table entry
    typedef struct packed {
        logic [nbr_addr_w-1:0] start_addr;
        logic [degree_w-1:0]   degree;
    } vertex_info_t;

    typedef struct packed {
        logic                  valid;
        logic [nbr_addr_w-1:0] start_addr;
        logic [degree_w-1:0]   degree;
        logic [pe_tag_w-1:0]   pe_tag;
    } nbr_req_t;

    typedef struct packed {
        logic                  cen;   // active low
        logic                  wen;   // active low, held high by the controller
        logic [nbr_addr_w-1:0] a;
    } sram_rd_t;

    // beat to the edge PEs
    typedef struct packed {
        logic                  valid;
        logic                  sos;
        logic                  eos;
        logic [pe_tag_w-1:0]   pe_tag;
        logic [degree_w-1:0]   degree;
        logic [nbr_word_w-1:0] data;
    } edge_beat_t;

endpackage

`default_nettype wire

/* neighbor_req_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_req_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  neighbor_pkg::nbr_req_t push_req,
    input  logic                   take,
    output neighbor_pkg::nbr_req_t head_req,
    output logic                   overflow
);
    import neighbor_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    nbr_req_t   mem [fifo_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic       full;
    logic       push_ok;

    assign full    = (count == cnt_w'(fifo_depth));
    assign push_ok = push_req.valid && !full;

    // head is shown as soon as the entry lands
    always_comb begin
        head_req       = mem[rd_ptr];
        head_req.valid = (count != '0);
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // take only comes with a valid head, no need to check empty
            if (take) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push_req.valid && full) begin
                overflow <= 1'b1; // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

/* neighbor_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module neighbor_sram (
    input  logic                                clk,
    input  logic                                mem_we,
    input  logic [neighbor_pkg::nbr_addr_w-1:0] mem_addr,
    input  logic [neighbor_pkg::nbr_word_w-1:0] mem_wdata,
    input  neighbor_pkg::sram_rd_t              sram_rd,
    output logic [neighbor_pkg::nbr_word_w-1:0] rd_data
);
    import neighbor_pkg::*;

    localparam int depth = 1 << nbr_addr_w;

    logic [nbr_word_w-1:0] mem [depth];

    // load port
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // read when selected and not writing, data one cycle later
    always_ff @(posedge clk) begin
        if (!sram_rd.cen && sram_rd.wen) begin
            rd_data <= mem[sram_rd.a];
        end
    end

endmodule

`default_nettype wire

/* vertex_info_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module vertex_info_lookup #(
    parameter int num_vertices = 16
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  neighbor_pkg::vertex_req_t            vertex_req,
    input  logic                                 tbl_we,
    input  logic [neighbor_pkg::vertex_id_w-1:0] tbl_addr,
    input  neighbor_pkg::vertex_info_t           tbl_data,
    output neighbor_pkg::nbr_req_t               lookup_req
);
    import neighbor_pkg::*;

    vertex_info_t info_tbl [num_vertices];
    vertex_info_t entry;

    // table load port
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            info_tbl[tbl_addr] <= tbl_data;
        end
    end

    assign entry = info_tbl[vertex_req.vertex_id];

    // one cycle from strobe to neighbor-list request
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lookup_req <= '0;
        end else begin
            lookup_req.valid      <= vertex_req.valid && (entry.degree != '0); // drop empty lists
            lookup_req.start_addr <= entry.start_addr;
            lookup_req.degree     <= entry.degree;
            lookup_req.pe_tag     <= vertex_req.pe_tag;
        end
    end

endmodule

`default_nettype wire
